//--- design/tag_mem_pkg.sv
// shared types and constants; banks hold 64 words of 16 bits, select only compares one code word
package tag_mem_pkg;

    localparam int WORD_BITS = 16;
    localparam int ADDR_BITS = 6;
    localparam int NUM_BANKS = 3;
    localparam int BIT_CNT_BITS = $clog2(WORD_BITS + 1);

    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [1:0] bank_t;

    // bank index doubles as its mem_sel bit
    localparam bank_t BANK_EPC = 2'd0;
    localparam bank_t BANK_S1 = 2'd1;
    localparam bank_t BANK_S2 = 2'd2;

    typedef enum logic [1:0] {CMD_NONE, CMD_SELECT, CMD_WRITE, CMD_READ} cmd_t;
    typedef enum logic [1:0] {JOB_IDLE, JOB_WRITE, JOB_READ} job_t;

    localparam addr_t CODE_WORD_ADDR = 6'd2;
    localparam logic [2:0] TARGET_SL = 3'd4;

    typedef enum logic [1:0] {KEEP, SET, CLEAR, TOGGLE} sel_effect_t;

    // flag effect by action, matching and non-matching tags
    localparam sel_effect_t SEL_MATCH_TBL [8] = '{SET, SET, KEEP, TOGGLE, CLEAR, CLEAR, KEEP, KEEP};
    localparam sel_effect_t SEL_MISS_TBL [8] = '{CLEAR, KEEP, CLEAR, KEEP, SET, KEEP, SET, TOGGLE};

    function automatic logic apply_effect(sel_effect_t effect, logic flag);
        case (effect)
            SET: return 1'b1;
            CLEAR: return 1'b0;
            TOGGLE: return ~flag;
            KEEP: return flag;
            default: return flag;
        endcase
    endfunction

endpackage

//--- design/bank_if.sv
// one instance per bank; only one bank may own the array port at a time
`timescale 1ns/1ps

interface bank_if;
    import tag_mem_pkg::*;

    // job from the decoder
    logic job_valid;
    job_t job;
    addr_t job_addr;
    addr_t job_count;
    word_t job_wdata;
    logic busy;
    logic wr_done;

    // array request
    logic pc_b;
    logic we;
    logic se;
    addr_t addr;
    word_t wdata;
    logic active;
    word_t rdata;

    // prefetched read word toward the serializer
    logic word_valid;
    word_t word;
    logic last;
    logic word_taken;

    modport bank (
        input job_valid, job, job_addr, job_count, job_wdata, rdata, word_taken,
        output busy, wr_done, pc_b, we, se, addr, wdata, active, word_valid, word, last
    );
    modport cmd (output job_valid, job, job_addr, job_count, job_wdata, input busy, wr_done);
    modport port (
        input pc_b, we, se, addr, wdata, active, word_valid, word, last,
        output rdata, word_taken
    );
endinterface

//--- design/cmd_decode.sv
// accepts one command or sensor sample while idle; writes only append, reads run high to low
`timescale 1ns/1ps

module cmd_decode (
    input logic clk,
    input logic reset,
    input logic packet_complete,
    input tag_mem_pkg::cmd_t cmd,
    input tag_mem_pkg::bank_t mem_bank,
    input tag_mem_pkg::addr_t word_ptr,
    input tag_mem_pkg::addr_t word_count,
    input tag_mem_pkg::word_t write_data,
    input logic [2:0] sel_target,
    input logic [2:0] sel_action,
    input tag_mem_pkg::word_t sel_mask,
    input logic sensor_ready,
    input tag_mem_pkg::bank_t sensor_id,
    input logic [7:0] adc_data,
    input logic [7:0] time_stamp,
    output logic inven_flag,
    output logic sl_flag,
    output logic [1:0] session,
    output logic busy,
    bank_if.cmd bus [tag_mem_pkg::NUM_BANKS]
);
    import tag_mem_pkg::*;

    logic [NUM_BANKS-1:0] valid_q;
    logic [NUM_BANKS-1:0] bank_busy;
    logic [NUM_BANKS-1:0] bank_wr_done;
    logic [NUM_BANKS-1:0] disp_sel;
    job_t disp_job;
    addr_t disp_addr;
    addr_t disp_count;
    word_t disp_wdata;
    job_t job_q;
    addr_t addr_q;
    addr_t count_q;
    word_t wdata_q;
    addr_t wr_ptr [NUM_BANKS];
    word_t code_q;
    logic pkt_ok;
    logic sns_ok;
    sel_effect_t effect;

    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bus
        assign bus[g].job_valid = valid_q[g];
        assign bus[g].job = job_q;
        assign bus[g].job_addr = addr_q;
        assign bus[g].job_count = count_q;
        assign bus[g].job_wdata = wdata_q;
        assign bank_busy[g] = bus[g].busy;
        assign bank_wr_done[g] = bus[g].wr_done;
    end

    assign busy = (|valid_q) | (|bank_busy);
    assign pkt_ok = packet_complete & ~busy;
    assign sns_ok = sensor_ready & ~busy & ~packet_complete
                    & (sensor_id == BANK_S1 || sensor_id == BANK_S2);
    assign effect = (sel_mask == code_q) ? SEL_MATCH_TBL[sel_action] : SEL_MISS_TBL[sel_action];

    always_comb begin
        disp_sel = '0;
        disp_job = JOB_IDLE;
        disp_addr = '0;
        disp_count = '0;
        disp_wdata = '0;
        if (pkt_ok) begin
            case (cmd)
                CMD_WRITE: if (mem_bank == BANK_EPC) begin
                    disp_sel[BANK_EPC] = 1'b1;
                    disp_job = JOB_WRITE;
                    disp_addr = wr_ptr[BANK_EPC];
                    disp_wdata = write_data;
                end
                CMD_READ: if (mem_bank <= BANK_S2 && word_count != '0) begin
                    disp_sel[mem_bank] = 1'b1;
                    disp_job = JOB_READ;
                    disp_addr = word_ptr + word_count - 1'b1; // top of range
                    disp_count = word_count;
                end
                CMD_SELECT, CMD_NONE: ; // select handled on the flags below
                default: ;
            endcase
        end else if (sns_ok) begin
            disp_sel[sensor_id] = 1'b1;
            disp_job = JOB_WRITE;
            disp_addr = wr_ptr[sensor_id];
            disp_wdata = {time_stamp, adc_data};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
            inven_flag <= 1'b1;
            sl_flag <= 1'b1;
            session <= 2'd0;
            code_q <= '0;
            for (int i = 0; i < NUM_BANKS; i++) begin
                wr_ptr[i] <= '0;
            end
        end else begin
            valid_q <= disp_sel;
            for (int i = 0; i < NUM_BANKS; i++) begin
                if (bank_wr_done[i]) wr_ptr[i] <= wr_ptr[i] + 1'b1;
            end
            if (bank_wr_done[BANK_EPC] && wr_ptr[BANK_EPC] == CODE_WORD_ADDR)
                code_q <= wdata_q; // select compares against this word
            if (pkt_ok && cmd == CMD_SELECT && mem_bank == BANK_EPC) begin
                if (sel_target < TARGET_SL) begin
                    session <= sel_target[1:0];
                    inven_flag <= apply_effect(effect, inven_flag);
                end else if (sel_target == TARGET_SL) begin
                    sl_flag <= apply_effect(effect, sl_flag);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (|disp_sel) begin
            job_q <= disp_job;
            addr_q <= disp_addr;
            count_q <= disp_count;
            wdata_q <= disp_wdata;
        end
    end

    a_one_job: assert property (@(posedge clk) disable iff (reset) $onehot0(valid_q))
        else $error("Fail: more than one bank job at %0t", $time);

endmodule

//--- design/bank_ctrl.sv
// one word buffer per bank; the next read word is fetched only after the current one is taken
`timescale 1ns/1ps

module bank_ctrl (
    input logic clk,
    input logic reset,
    bank_if.bank b
);
    import tag_mem_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_W_PRE,
        S_W_DRIVE,
        S_W_DONE,
        S_R_PRE,
        S_R_SENSE,
        S_R_CAP,
        S_R_WAIT
    } state_t;

    state_t state;
    addr_t addr_q;
    addr_t rem_q;
    word_t wdata_q;
    word_t word_q;
    logic word_valid_q;
    logic last_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            word_valid_q <= 1'b0;
        end else begin
            case (state)
                S_IDLE: if (b.job_valid) begin
                    if (b.job == JOB_WRITE) state <= S_W_PRE;
                    else if (b.job == JOB_READ) state <= S_R_PRE;
                end
                S_W_PRE: state <= S_W_DRIVE;
                S_W_DRIVE: state <= S_W_DONE;
                S_W_DONE: state <= S_IDLE;
                S_R_PRE: state <= S_R_SENSE;
                S_R_SENSE: state <= S_R_CAP;
                S_R_CAP: begin
                    state <= S_R_WAIT;
                    word_valid_q <= 1'b1;
                end
                S_R_WAIT: if (b.word_taken) begin
                    word_valid_q <= 1'b0;
                    state <= last_q ? S_IDLE : S_R_PRE; // prefetch next while shifting
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && b.job_valid) begin
            addr_q <= b.job_addr;
            rem_q <= b.job_count;
            wdata_q <= b.job_wdata;
        end else if (state == S_R_CAP) begin
            word_q <= b.rdata;
            last_q <= (rem_q == addr_t'(1));
            rem_q <= rem_q - 1'b1;
        end else if (state == S_R_WAIT && b.word_taken) begin
            addr_q <= addr_q - 1'b1; // descending order
        end
    end

    assign b.busy = (state != S_IDLE);
    assign b.wr_done = (state == S_W_DONE);
    assign b.pc_b = ~(state == S_W_PRE || state == S_R_PRE); // low during precharge
    assign b.we = (state == S_W_DRIVE || state == S_W_DONE);
    assign b.se = (state == S_R_SENSE || state == S_R_CAP);
    assign b.addr = addr_q;
    assign b.wdata = wdata_q;
    assign b.active = ~(state == S_IDLE || state == S_R_WAIT);
    assign b.word_valid = word_valid_q;
    assign b.word = word_q;
    assign b.last = last_q;

    a_we_se: assert property (@(posedge clk) disable iff (reset) !(b.we && b.se))
        else $error("Fail: we and se both high at %0t", $time);

    // decoder must hold jobs back while this bank works
    a_job_idle: assert property (@(posedge clk) disable iff (reset) b.job_valid |-> !b.busy)
        else $error("Fail: job sent to busy bank at %0t", $time);

endmodule

//--- design/array_port.sv
// relies on the decoder to keep banks from overlapping; idle pins hold pc_b high
`timescale 1ns/1ps

module array_port (
    input logic clk,
    input logic reset,
    bank_if.port bus [tag_mem_pkg::NUM_BANKS],
    input tag_mem_pkg::word_t mem_read_in,
    output tag_mem_pkg::word_t mem_data_out,
    output tag_mem_pkg::addr_t mem_address,
    output logic [tag_mem_pkg::NUM_BANKS-1:0] mem_sel,
    output logic pc_b,
    output logic we,
    output logic se,
    output logic rd_word_valid,
    output tag_mem_pkg::word_t rd_word,
    output logic rd_last,
    input logic rd_taken
);
    import tag_mem_pkg::*;

    logic [NUM_BANKS-1:0] act;
    logic [NUM_BANKS-1:0] req_pcb;
    logic [NUM_BANKS-1:0] req_we;
    logic [NUM_BANKS-1:0] req_se;
    logic [NUM_BANKS-1:0] wv;
    logic [NUM_BANKS-1:0] wl;
    addr_t req_addr [NUM_BANKS];
    word_t req_wdata [NUM_BANKS];
    word_t wword [NUM_BANKS];

    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_tap
        assign act[g] = bus[g].active;
        assign req_pcb[g] = bus[g].pc_b;
        assign req_we[g] = bus[g].we;
        assign req_se[g] = bus[g].se;
        assign req_addr[g] = bus[g].addr;
        assign req_wdata[g] = bus[g].wdata;
        assign wv[g] = bus[g].word_valid;
        assign wl[g] = bus[g].last;
        assign wword[g] = bus[g].word;
        assign bus[g].rdata = mem_read_in; // every bank sees the sense data
        assign bus[g].word_taken = rd_taken & wv[g];
    end

    always_comb begin
        mem_sel = act; // bit index equals bank index
        pc_b = 1'b1;
        we = 1'b0;
        se = 1'b0;
        mem_address = '0;
        mem_data_out = '0;
        rd_word_valid = 1'b0;
        rd_word = '0;
        rd_last = 1'b0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (act[i]) begin
                pc_b = req_pcb[i];
                we = req_we[i];
                se = req_se[i];
                mem_address = req_addr[i];
                mem_data_out = req_wdata[i];
            end
            if (wv[i]) begin
                rd_word_valid = 1'b1;
                rd_word = wword[i];
                rd_last = wl[i];
            end
        end
    end

    a_one_owner: assert property (@(posedge clk) disable iff (reset) $onehot0(act))
        else $error("Fail: two banks on the array port at %0t", $time);

endmodule

//--- design/tx_serializer.sv
// data_clk must stay high and low for at least one clk each; one bit per data_clk rise
`timescale 1ns/1ps

module tx_serializer (
    input logic clk,
    input logic reset,
    input logic data_clk,
    input logic rd_word_valid,
    input tag_mem_pkg::word_t rd_word,
    input logic rd_last,
    output logic rd_taken,
    output logic tx_bit,
    output logic tx_bit_valid,
    output logic tx_done
);
    import tag_mem_pkg::*;

    logic dclk_q;
    logic dclk_rise;
    logic [BIT_CNT_BITS-1:0] bits_left;
    word_t shreg;
    logic last_q;
    logic fin_q;

    assign dclk_rise = data_clk & ~dclk_q;
    assign rd_taken = rd_word_valid & (bits_left == '0); // load only when empty

    always_ff @(posedge clk) begin
        if (reset) begin
            dclk_q <= 1'b0;
            bits_left <= '0;
            tx_bit <= 1'b0;
            tx_bit_valid <= 1'b0;
            fin_q <= 1'b0;
            tx_done <= 1'b0;
        end else begin
            dclk_q <= data_clk;
            tx_bit_valid <= 1'b0;
            fin_q <= 1'b0;
            tx_done <= fin_q; // one clk after the final bit
            if (rd_taken) begin
                bits_left <= (BIT_CNT_BITS)'(WORD_BITS);
            end else if (dclk_rise && bits_left != '0) begin
                tx_bit <= shreg[WORD_BITS-1];
                tx_bit_valid <= 1'b1;
                bits_left <= bits_left - 1'b1;
                fin_q <= last_q && (bits_left == (BIT_CNT_BITS)'(1));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_taken) begin
            shreg <= rd_word;
            last_q <= rd_last;
        end else if (dclk_rise && bits_left != '0) begin
            shreg <= shreg << 1; // msb first
        end
    end

endmodule

//--- design/tag_mem_top.sv
// commands and sensor samples are ignored while busy; tx_done is a single clk pulse
`timescale 1ns/1ps

module tag_mem_top (
    input logic clk,
    input logic reset,
    input logic data_clk,
    input logic packet_complete,
    input tag_mem_pkg::cmd_t cmd,
    input tag_mem_pkg::bank_t mem_bank,
    input tag_mem_pkg::addr_t word_ptr,
    input tag_mem_pkg::addr_t word_count,
    input tag_mem_pkg::word_t write_data,
    input logic [2:0] sel_target,
    input logic [2:0] sel_action,
    input tag_mem_pkg::word_t sel_mask,
    input logic sensor_ready,
    input tag_mem_pkg::bank_t sensor_id,
    input logic [7:0] adc_data,
    input logic [7:0] time_stamp,
    input tag_mem_pkg::word_t mem_read_in,
    output tag_mem_pkg::word_t mem_data_out,
    output tag_mem_pkg::addr_t mem_address,
    output logic [tag_mem_pkg::NUM_BANKS-1:0] mem_sel,
    output logic pc_b,
    output logic we,
    output logic se,
    output logic inven_flag,
    output logic sl_flag,
    output logic [1:0] session,
    output logic busy,
    output logic tx_bit,
    output logic tx_bit_valid,
    output logic tx_done
);
    import tag_mem_pkg::*;

    bank_if bus [NUM_BANKS] ();

    logic rd_word_valid;
    word_t rd_word;
    logic rd_last;
    logic rd_taken;

    cmd_decode u_cmd (
        .clk, .reset, .packet_complete, .cmd, .mem_bank, .word_ptr, .word_count,
        .write_data, .sel_target, .sel_action, .sel_mask, .sensor_ready, .sensor_id,
        .adc_data, .time_stamp, .inven_flag, .sl_flag, .session, .busy, .bus(bus)
    );

    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        bank_ctrl u_bank (.clk, .reset, .b(bus[g]));
    end

    array_port u_port (
        .clk, .reset, .bus(bus), .mem_read_in, .mem_data_out, .mem_address, .mem_sel,
        .pc_b, .we, .se, .rd_word_valid, .rd_word, .rd_last, .rd_taken
    );

    tx_serializer u_tx (
        .clk, .reset, .data_clk, .rd_word_valid, .rd_word, .rd_last, .rd_taken,
        .tx_bit, .tx_bit_valid, .tx_done
    );

endmodule

//--- tb/array_model.sv
// behavioral array, writes need we with pc_b high; sense data is combinational while se is high
`timescale 1ns/1ps

module array_model (
    input logic clk,
    input logic [tag_mem_pkg::NUM_BANKS-1:0] mem_sel,
    input logic pc_b,
    input logic we,
    input logic se,
    input tag_mem_pkg::addr_t mem_address,
    input tag_mem_pkg::word_t mem_data_out,
    output tag_mem_pkg::word_t mem_read_in
);
    import tag_mem_pkg::*;

    word_t mem [NUM_BANKS][2**ADDR_BITS];

    initial begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int a = 0; a < 2**ADDR_BITS; a++) begin
                mem[b][a] = {b[1:0], ~a[5:0], b[1:0], a[5:0]}; // bank and address both visible
            end
        end
    end

    always @(posedge clk) begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (mem_sel[b] && we && pc_b) mem[b][mem_address] = mem_data_out;
        end
    end

    always_comb begin
        mem_read_in = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (mem_sel[b] && se) mem_read_in = mem[b][mem_address]; // sense amp output
        end
    end

endmodule

//--- tb/tag_mem_tb.sv
// stops at the first error; data_clk runs at clk/8 and every wait gives up after a bounded count
`timescale 1ns/1ps

module tag_mem_tb;
    import tag_mem_pkg::*;

    logic clk;
    logic reset;
    logic data_clk;
    logic packet_complete;
    cmd_t cmd;
    bank_t mem_bank;
    addr_t word_ptr;
    addr_t word_count;
    word_t write_data;
    logic [2:0] sel_target;
    logic [2:0] sel_action;
    word_t sel_mask;
    logic sensor_ready;
    bank_t sensor_id;
    logic [7:0] adc_data;
    logic [7:0] time_stamp;
    word_t mem_read_in;
    word_t mem_data_out;
    addr_t mem_address;
    logic [NUM_BANKS-1:0] mem_sel;
    logic pc_b;
    logic we;
    logic se;
    logic inven_flag;
    logic sl_flag;
    logic [1:0] session;
    logic busy;
    logic tx_bit;
    logic tx_bit_valid;
    logic tx_done;

    logic [2:0] dclk_div = 3'd0;
    logic [31:0] lfsr;

    // reference state
    word_t exp_mem [NUM_BANKS][2**ADDR_BITS];
    int exp_ptr [NUM_BANKS];
    word_t exp_code;
    logic exp_inven;
    logic exp_sl;
    logic [1:0] exp_session;

    tag_mem_top uut (.*);

    array_model mem_model (
        .clk, .mem_sel, .pc_b, .we, .se, .mem_address, .mem_data_out, .mem_read_in
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(negedge clk) dclk_div <= dclk_div + 3'd1;
    assign data_clk = dclk_div[2];

    task automatic end_failed();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic value_error(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        end_failed();
    endtask

    task automatic timeout_error(input string what);
        $display("gave up at %0t ns waiting for %s", $time, what);
        end_failed();
    endtask

    a_sel_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(mem_sel))
        else value_error($sformatf("mem_sel %b has more than one bank", mem_sel));
    a_we_se: assert property (@(posedge clk) disable iff (reset) !(we && se))
        else value_error("we and se high together");
    a_idle_pins: assert property (@(posedge clk) disable iff (reset)
        (mem_sel == '0) |-> (pc_b && !we && !se))
        else value_error("array pins not idle without a selected bank");

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output word_t val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[WORD_BITS-2:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic logic predict_flag(input logic hit, input logic [2:0] action,
                                          input logic flag);
        logic res;
        res = flag;
        if (hit) begin
            case (action)
                3'd0, 3'd1: res = 1'b1;
                3'd3: res = ~flag;
                3'd4, 3'd5: res = 1'b0;
                default: res = flag;
            endcase
        end else begin
            case (action)
                3'd0, 3'd2: res = 1'b0;
                3'd4, 3'd6: res = 1'b1;
                3'd7: res = ~flag;
                default: res = flag;
            endcase
        end
        return res;
    endfunction

    task automatic pulse_packet();
        packet_complete = 1'b1;
        @(negedge clk);
        packet_complete = 1'b0;
    endtask

    task automatic wait_idle(input string what);
        int n;
        n = 0;
        while (busy) begin
            @(negedge clk);
            n++;
            if (n > 200) timeout_error(what);
        end
    endtask

    task automatic check_array(input int bank, input int addr, input word_t expect_w);
        assert (mem_model.mem[bank][addr] == expect_w)
            else value_error($sformatf("bank %0d addr %0d holds %h, expected %h",
                                       bank, addr, mem_model.mem[bank][addr], expect_w));
    endtask

    task automatic write_epc(input word_t w);
        cmd = CMD_WRITE;
        mem_bank = BANK_EPC;
        write_data = w;
        pulse_packet();
        assert (busy) else value_error("busy did not rise after an EPC write");
        wait_idle("an EPC write to finish");
        exp_mem[BANK_EPC][exp_ptr[BANK_EPC]] = w;
        if (exp_ptr[BANK_EPC] == int'(CODE_WORD_ADDR)) exp_code = w;
        exp_ptr[BANK_EPC]++;
    endtask

    task automatic store_sample(input bank_t id, input logic [7:0] ts, input logic [7:0] adc);
        sensor_id = id;
        time_stamp = ts;
        adc_data = adc;
        sensor_ready = 1'b1;
        @(negedge clk);
        sensor_ready = 1'b0;
        assert (busy) else value_error("busy did not rise after sensor_ready");
        wait_idle("a sensor store to finish");
        exp_mem[id][exp_ptr[id]] = {ts, adc};
        exp_ptr[id]++;
    endtask

    task automatic read_range(input bank_t bank, input int ptr, input int count);
        word_t w;
        int n;
        cmd = CMD_READ;
        mem_bank = bank;
        word_ptr = addr_t'(ptr);
        word_count = addr_t'(count);
        pulse_packet();
        for (int k = count - 1; k >= 0; k--) begin
            w = exp_mem[bank][ptr + k]; // highest address first
            for (int b = WORD_BITS - 1; b >= 0; b--) begin
                n = 0;
                while (!tx_bit_valid) begin
                    assert (!tx_done) else value_error("tx_done before the last bit");
                    @(negedge clk);
                    n++;
                    if (n > 100) timeout_error("the next serial bit");
                end
                assert (tx_bit == w[b])
                    else value_error($sformatf("bank %0d word %0d bit %0d is %b, expected %b",
                                               bank, ptr + k, b, tx_bit, w[b]));
                @(negedge clk);
            end
        end
        assert (tx_done) else value_error("tx_done not one clk after the last bit");
        repeat (24) begin
            @(negedge clk);
            assert (!tx_done && !tx_bit_valid)
                else value_error("extra tx_done or serial bit after the read");
        end
        assert (!busy) else value_error("busy still high after the read");
    endtask

    task automatic select_cmd(input bank_t bank, input logic [2:0] target,
                              input logic [2:0] action, input word_t mask);
        logic hit;
        hit = (mask == exp_code);
        cmd = CMD_SELECT;
        mem_bank = bank;
        sel_target = target;
        sel_action = action;
        sel_mask = mask;
        if (bank == BANK_EPC) begin
            if (target < TARGET_SL) begin
                exp_session = target[1:0];
                exp_inven = predict_flag(hit, action, exp_inven);
            end else if (target == TARGET_SL) begin
                exp_sl = predict_flag(hit, action, exp_sl);
            end
        end
        pulse_packet();
        assert (!busy) else value_error("select raised busy");
        assert (inven_flag == exp_inven && sl_flag == exp_sl && session == exp_session)
            else value_error($sformatf("target %0d action %0d hit %b gave %b %b %0d, want %b %b %0d",
                                       target, action, hit, inven_flag, sl_flag, session,
                                       exp_inven, exp_sl, exp_session));
    endtask

    initial begin
        word_t w;
        word_t r;
        word_t keep;
        int addr;
        lfsr = 32'hfdd7;
        reset = 1'b1;
        packet_complete = 1'b0;
        cmd = CMD_NONE;
        mem_bank = BANK_EPC;
        word_ptr = '0;
        word_count = '0;
        write_data = '0;
        sel_target = '0;
        sel_action = '0;
        sel_mask = '0;
        sensor_ready = 1'b0;
        sensor_id = BANK_EPC;
        adc_data = '0;
        time_stamp = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            exp_ptr[i] = 0;
        end
        exp_code = '0;
        exp_inven = 1'b1;
        exp_sl = 1'b1;
        exp_session = 2'd0;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        // inactive outputs after reset
        assert (pc_b && !we && !se && mem_sel == '0 && !busy && !tx_bit_valid && !tx_done)
            else value_error("array or handshake outputs active after reset");
        assert (inven_flag && sl_flag && session == 2'd0)
            else value_error("tag flags wrong after reset");

        for (int i = 0; i < 5; i++) begin
            take_bits(16, w);
            write_epc(w);
            check_array(BANK_EPC, i, w);
        end
        read_range(BANK_EPC, 1, 3);

        for (int i = 0; i < 2; i++) begin
            take_bits(16, r);
            store_sample(BANK_S2, r[15:8], r[7:0]);
            check_array(BANK_S2, i, r);
        end
        read_range(BANK_S2, 0, 2);

        // matching mask, then a mask that differs in at least bit 0
        take_bits(16, r);
        for (int m = 0; m < 2; m++) begin
            for (int t = 0; t < 6; t++) begin
                for (int a = 0; a < 8; a++) begin
                    select_cmd(BANK_EPC, t[2:0], a[2:0],
                               (m == 0) ? exp_code : exp_code ^ (r | 16'h0001));
                end
            end
        end
        select_cmd(BANK_S1, 3'd0, 3'd3, exp_code); // non-EPC select leaves flags alone

        // second packet while busy must be dropped
        take_bits(16, w);
        take_bits(16, r);
        addr = exp_ptr[BANK_EPC];
        keep = mem_model.mem[BANK_EPC][addr + 1];
        cmd = CMD_WRITE;
        mem_bank = BANK_EPC;
        write_data = w;
        pulse_packet();
        assert (busy) else value_error("busy low right after an accepted write");
        write_data = r;
        pulse_packet();
        wait_idle("the write under test to finish");
        exp_mem[BANK_EPC][addr] = w;
        exp_ptr[BANK_EPC]++;
        check_array(BANK_EPC, addr, w);
        check_array(BANK_EPC, addr + 1, keep);
        take_bits(16, r);
        write_epc(r);
        check_array(BANK_EPC, addr + 1, r); // pointer moved only once

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- tb.f
design/tag_mem_pkg.sv
design/bank_if.sv
design/cmd_decode.sv
design/bank_ctrl.sv
design/array_port.sv
design/tx_serializer.sv
design/tag_mem_top.sv
tb/array_model.sv
tb/tag_mem_tb.sv

//--- run.sh
#!/bin/sh
# builds and runs the tag memory testbench, exit status follows the simulation
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tag_mem_tb -f tb.f -o tag_mem_sim
./obj_dir/tag_mem_sim
